// ==== rng_pkg.sv ====
// RNG output path definitions
package rng_pkg;

    // ------------------------------------------------
    // Trivium sizes
    // ------------------------------------------------
    localparam int KEY_BITS      = 80;                 // Secret key width
    localparam int IV_BITS       = 80;                 // Initial value width
    localparam int STATE_BITS    = 288;                // Three shift registers, 93 + 84 + 111
    localparam int WARMUP_ROUNDS = 4 * STATE_BITS;     // Discarded rounds after load (1152)

    // ------------------------------------------------
    // Word and byte path
    // ------------------------------------------------
    localparam int WORD_BITS      = 64;                // Keystream word pushed to the FIFO
    localparam int BYTE_BITS      = 8;                 // CPU-side byte
    localparam int BYTES_PER_WORD = WORD_BITS / BYTE_BITS;
    localparam int FIFO_DEPTH     = 4;                 // Word FIFO entries
    localparam int CREDIT_BITS    = 3;                 // Holds 0 .. FIFO_DEPTH
    localparam int BURST_BYTES    = 4;                 // Bytes per burst request

    // Derived counter widths
    localparam int WARMUP_CNT_BITS = $clog2(WARMUP_ROUNDS);
    localparam int WORD_IDX_BITS   = $clog2(WORD_BITS);       // Bit slot inside a word
    localparam int FIFO_PTR_BITS   = $clog2(FIFO_DEPTH);
    localparam int BYTE_IDX_BITS   = $clog2(BYTES_PER_WORD);  // Byte slot inside a word
    localparam int REQ_CNT_BITS    = $clog2(BURST_BYTES + 1); // Bytes left in a request

    // ------------------------------------------------
    // Opcodes and FSM states
    // ------------------------------------------------
    typedef enum logic {
        REQ_BYTE  = 1'b0,   // One byte
        REQ_BURST = 1'b1    // BURST_BYTES bytes
    } rand_req_t;

    typedef enum logic [1:0] {
        TRIV_IDLE   = 2'd0, // No seed yet
        TRIV_WARMUP = 2'd1, // Rounds without output
        TRIV_RUN    = 2'd2  // Keystream out
    } triv_state_t;

    typedef enum logic [1:0] {
        SRV_IDLE  = 2'd0,   // Waiting for a request
        SRV_SEND  = 2'd1,   // Bytes going out
        SRV_FETCH = 2'd2    // Pulling the next word from the FIFO
    } srv_state_t;

endpackage

// ==== trivium_core.sv ====
// Trivium keystream generator
`timescale 1ns/1ns

module trivium_core (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          seed_load_i,     // One-cycle load strobe
    input  logic [rng_pkg::KEY_BITS-1:0]  seed_key_i,      // Bit 0 is K1
    input  logic [rng_pkg::IV_BITS-1:0]   seed_iv_i,       // Bit 0 is IV1
    input  logic                          credit_return_i, // One pulse per FIFO pop
    output logic                          ks_valid_o,      // Word push to the FIFO
    output logic [rng_pkg::WORD_BITS-1:0] ks_word_o
);
    import rng_pkg::*;

    triv_state_t                fsm_q;
    logic [STATE_BITS-1:0]      s_q;          // s_q[i-1] holds Trivium bit s_i
    logic [STATE_BITS-1:0]      s_init;
    logic [STATE_BITS-1:0]      s_next;
    logic [WARMUP_CNT_BITS-1:0] round_q;
    logic [WORD_IDX_BITS-1:0]   bit_idx_q;    // Next bit slot of the word
    logic                       word_full_q;  // All 64 bits present
    logic [WORD_BITS-1:0]       word_q;
    logic [CREDIT_BITS-1:0]     credit_q;     // Free FIFO entries as seen here
    logic                       t1;
    logic                       t2;
    logic                       t3;
    logic                       n1;
    logic                       n2;
    logic                       n3;
    logic                       z;            // Keystream bit of this round
    logic                       frozen;
    logic                       shift_en;
    logic                       advance;

    // ------------------------------------------------
    // Round function
    // ------------------------------------------------
    // Key into s1..s80, IV into s94..s173, s286..s288 set, rest zero
    assign s_init = {3'b111, {(STATE_BITS - KEY_BITS - IV_BITS - 16){1'b0}},
                     seed_iv_i, 13'b0, seed_key_i};

    always_comb begin
        t1 = s_q[65] ^ s_q[92];             // s66 + s93
        t2 = s_q[161] ^ s_q[176];           // s162 + s177
        t3 = s_q[242] ^ s_q[287];           // s243 + s288
        z  = t1 ^ t2 ^ t3;
        // Feedback terms with the AND taps
        n1 = t1 ^ (s_q[90] & s_q[91]) ^ s_q[170];
        n2 = t2 ^ (s_q[174] & s_q[175]) ^ s_q[263];
        n3 = t3 ^ (s_q[285] & s_q[286]) ^ s_q[68];
        // Each register shifts up by one, feedback enters at its bottom
        s_next = {s_q[286:177], n2, s_q[175:93], n1, s_q[91:0], n3};
    end

    // Full word with no credit stops everything
    assign frozen   = word_full_q && (credit_q == '0);
    assign shift_en = (fsm_q == TRIV_RUN) && !frozen;
    assign advance  = (fsm_q == TRIV_WARMUP) || shift_en;

    always_ff @(posedge clk_i) begin
        if (seed_load_i) begin
            s_q <= s_init;
        end else if (advance) begin
            s_q <= s_next;
        end
    end

    // Bit t lands in slot t mod 64
    always_ff @(posedge clk_i) begin
        if (shift_en) begin
            word_q[bit_idx_q] <= z;
        end
    end

    // ------------------------------------------------
    // Load, warm-up and run control
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fsm_q       <= TRIV_IDLE;
            round_q     <= '0;
            bit_idx_q   <= '0;
            word_full_q <= 1'b0;
        end else if (seed_load_i) begin
            fsm_q       <= TRIV_WARMUP;   // Restart from any state
            round_q     <= '0;
            bit_idx_q   <= '0;
            word_full_q <= 1'b0;
        end else begin
            case (fsm_q)
                TRIV_WARMUP: begin
                    round_q <= round_q + 1'b1;
                    if (round_q == WARMUP_CNT_BITS'(WARMUP_ROUNDS - 1)) begin
                        fsm_q <= TRIV_RUN;
                    end
                end
                TRIV_RUN: begin
                    if (shift_en) begin
                        bit_idx_q   <= bit_idx_q + 1'b1;  // Wraps to 0 after slot 63
                        word_full_q <= (bit_idx_q == '1);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------
    // Credit counter
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= CREDIT_BITS'(FIFO_DEPTH);
        end else if (seed_load_i) begin
            credit_q <= CREDIT_BITS'(FIFO_DEPTH);   // FIFO is flushed by the same strobe
        end else begin
            case ({ks_valid_o, credit_return_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;      // Push and return cancel
            endcase
        end
    end

    assign ks_valid_o = word_full_q && (credit_q != '0);
    assign ks_word_o  = word_q;

    // Word only leaves with credit in hand
    a_push_credit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ks_valid_o |-> (credit_q != '0))
        else $error("trivium_core: push with zero credit");

    // FIFO must not return more credits than words it took
    a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_q <= CREDIT_BITS'(FIFO_DEPTH))
        else $error("trivium_core: credit count above FIFO depth");

endmodule

// ==== keystream_fifo.sv ====
// Keystream word FIFO
`timescale 1ns/1ns

module keystream_fifo (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,         // Seed load, drop all words
    input  logic                          push_i,
    input  logic [rng_pkg::WORD_BITS-1:0] push_word_i,
    input  logic                          pop_i,
    output logic                          word_avail_o,
    output logic [rng_pkg::WORD_BITS-1:0] head_word_o,
    output logic                          credit_return_o  // One cycle after each pop
);
    import rng_pkg::*;

    logic [WORD_BITS-1:0]     mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr_q;
    logic [FIFO_PTR_BITS-1:0] rd_ptr_q;
    logic [CREDIT_BITS-1:0]   count_q;    // Entries in use
    logic                     do_push;
    logic                     do_pop;

    // Flush wins over both ports
    assign do_push = push_i && !flush_i;
    assign do_pop  = pop_i && !flush_i;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_word_i;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ------------------------------------------------
    // Credit return
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= do_pop;    // No credit for flushed words
        end
    end

    assign word_avail_o = (count_q != '0);
    assign head_word_o  = mem_q[rd_ptr_q];  // Valid only with word_avail_o

    // Generator credit must keep a full FIFO from seeing a push
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (count_q != CREDIT_BITS'(FIFO_DEPTH)))
        else $error("keystream_fifo: push while full");

    // Server pops only what it saw available
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> (count_q != '0))
        else $error("keystream_fifo: pop while empty");

endmodule

// ==== byte_server.sv ====
// Random byte server
`timescale 1ns/1ns

module byte_server (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,         // Seed load, drop the held word
    input  logic                          rand_req_i,
    input  rng_pkg::rand_req_t            rand_req_type_i,
    input  logic                          stall_i,         // Temperature alarm and the like
    input  logic                          word_avail_i,
    input  logic [rng_pkg::WORD_BITS-1:0] head_word_i,
    output logic                          word_pop_o,
    output logic [rng_pkg::BYTE_BITS-1:0] rand_byte_o,
    output logic                          rand_valid_o,
    output logic                          busy_o
);
    import rng_pkg::*;

    srv_state_t               state_q;
    logic [WORD_BITS-1:0]     word_q;       // Local copy of the current word
    logic [BYTE_IDX_BITS-1:0] byte_idx_q;   // Next unused byte, LSB first
    logic [REQ_CNT_BITS-1:0]  remain_q;     // Bytes still owed to the request
    logic                     held_q;       // word_q has unused bytes
    logic                     req_accept;
    logic                     byte_fire;

    assign busy_o     = (state_q != SRV_IDLE);
    assign req_accept = rand_req_i && !busy_o;
    assign byte_fire  = (state_q == SRV_SEND) && !stall_i && !flush_i;

    // Pop straight from the FIFO head
    assign word_pop_o = (state_q == SRV_FETCH) && word_avail_i && !flush_i;

    // ------------------------------------------------
    // Word copy
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (word_pop_o) begin
            word_q <= head_word_i;
        end
    end

    // ------------------------------------------------
    // Request FSM
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= SRV_IDLE;
            byte_idx_q <= '0;
            remain_q   <= '0;
            held_q     <= 1'b0;
        end else begin
            case (state_q)
                SRV_IDLE: begin
                    if (req_accept) begin
                        remain_q <= (rand_req_type_i == REQ_BURST) ?
                                    REQ_CNT_BITS'(BURST_BYTES) : REQ_CNT_BITS'(1);
                        // Leftover bytes from the last request go first
                        state_q  <= (held_q && !flush_i) ? SRV_SEND : SRV_FETCH;
                    end
                end
                SRV_FETCH: begin
                    if (word_pop_o) begin
                        byte_idx_q <= '0;
                        held_q     <= 1'b1;
                        state_q    <= SRV_SEND;
                    end
                end
                SRV_SEND: begin
                    if (flush_i) begin
                        state_q <= SRV_FETCH;     // Request continues on the new stream
                    end else if (byte_fire) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        remain_q   <= remain_q - 1'b1;
                        if (byte_idx_q == '1) begin
                            held_q <= 1'b0;       // Last byte of the word used
                        end
                        if (remain_q == REQ_CNT_BITS'(1)) begin
                            state_q <= SRV_IDLE;
                        end else if (byte_idx_q == '1) begin
                            state_q <= SRV_FETCH;
                        end
                    end
                end
                default: state_q <= SRV_IDLE;
            endcase
            if (flush_i) begin
                held_q <= 1'b0;   // Old stream bytes never leave
            end
        end
    end

    // ------------------------------------------------
    // Byte output
    // ------------------------------------------------
    assign rand_valid_o = byte_fire;
    assign rand_byte_o  = byte_fire ? word_q[byte_idx_q*BYTE_BITS +: BYTE_BITS] : '0;

    // Alarm blocks the output in the same cycle
    a_stall_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !rand_valid_o)
        else $error("byte_server: byte out during stall");

endmodule

// ==== rng_top.sv ====
// RNG output path top level
`timescale 1ns/1ns

module rng_top (
    // Clock and reset
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Seed from the conditioner side
    input  logic                          seed_load_i,     // One-cycle pulse
    input  logic [rng_pkg::KEY_BITS-1:0]  seed_key_i,
    input  logic [rng_pkg::IV_BITS-1:0]   seed_iv_i,

    // CPU request and byte output
    input  logic                          rand_req_i,
    input  rng_pkg::rand_req_t            rand_req_type_i, // Single byte or burst
    output logic                          busy_o,          // Requests ignored while high
    output logic [rng_pkg::BYTE_BITS-1:0] rand_byte_o,
    output logic                          rand_valid_o,

    // Output freeze
    input  logic                          stall_i
);
    import rng_pkg::*;

    // Generator to FIFO
    logic                 ks_valid;
    logic [WORD_BITS-1:0] ks_word;
    logic                 credit_return;

    // FIFO to server
    logic                 word_avail;
    logic [WORD_BITS-1:0] head_word;
    logic                 word_pop;

    // ------------------------------------------------
    // Producer, buffer, consumer
    // ------------------------------------------------
    trivium_core u_trivium (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .seed_load_i     (seed_load_i),
        .seed_key_i      (seed_key_i),
        .seed_iv_i       (seed_iv_i),
        .credit_return_i (credit_return),
        .ks_valid_o      (ks_valid),
        .ks_word_o       (ks_word)
    );

    keystream_fifo u_fifo (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (seed_load_i),   // New seed empties the buffer
        .push_i          (ks_valid),
        .push_word_i     (ks_word),
        .pop_i           (word_pop),
        .word_avail_o    (word_avail),
        .head_word_o     (head_word),
        .credit_return_o (credit_return)
    );

    byte_server u_server (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (seed_load_i),   // And the held word
        .rand_req_i      (rand_req_i),
        .rand_req_type_i (rand_req_type_i),
        .stall_i         (stall_i),
        .word_avail_i    (word_avail),
        .head_word_i     (head_word),
        .word_pop_o      (word_pop),
        .rand_byte_o     (rand_byte_o),
        .rand_valid_o    (rand_valid_o),
        .busy_o          (busy_o)
    );

endmodule

// ==== tb_trivium_ref.svh ====
// Trivium reference keystream
`ifndef TB_TRIVIUM_REF_SVH
`define TB_TRIVIUM_REF_SVH

// ------------------------------------------------
// Keystream word n for a key and IV
// ------------------------------------------------
// Standard Trivium with state bits s1..s288, bit t of the stream in slot t mod 64
function automatic logic [WORD_BITS-1:0] trivium_ref_word(
    input logic [KEY_BITS-1:0] key,
    input logic [IV_BITS-1:0]  iv,
    input int                  n
);
    logic [288:1]         s;        // s[i] is state bit s_i
    logic [WORD_BITS-1:0] word;
    logic                 t1;
    logic                 t2;
    logic                 t3;
    logic                 z;
    int                   r;
    int                   first;    // Round that yields bit 0 of word n

    s          = '0;
    s[80:1]    = key;               // K1 in s1
    s[173:94]  = iv;                // IV1 in s94
    s[288:286] = 3'b111;
    word       = '0;
    first      = WARMUP_ROUNDS + n * WORD_BITS;

    for (r = 0; r < first + WORD_BITS; r++) begin
        t1 = s[66] ^ s[93];
        t2 = s[162] ^ s[177];
        t3 = s[243] ^ s[288];
        z  = t1 ^ t2 ^ t3;
        t1 = t1 ^ (s[91] & s[92]) ^ s[171];
        t2 = t2 ^ (s[175] & s[176]) ^ s[264];
        t3 = t3 ^ (s[286] & s[287]) ^ s[69];
        // Rotate each register, feedback enters at its first bit
        s[93:1]    = {s[92:1], t3};
        s[177:94]  = {s[176:94], t1};
        s[288:178] = {s[287:178], t2};
        if (r >= first) begin
            word[r - first] = z;    // Output bits only after warm-up
        end
    end
    return word;
endfunction

`endif

// ==== tb_rng_top.sv ====
// RNG output path testbench
`timescale 1ns/1ns

module tb_rng_top;
    import rng_pkg::*;

    `include "tb_trivium_ref.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int PAUSE_CYCLES = (FIFO_DEPTH + 2) * WORD_BITS;  // FIFO fills, core freezes
    localparam int NUM_REQ      = 80;                            // All phases together
    localparam int WORD_CYCLES  = WORD_BITS + 16;                // Worst case, gap and stall
    localparam int TIMEOUT_NS   = (NUM_REQ * WORD_CYCLES + 2 * (WARMUP_ROUNDS + WORD_BITS)
                                   + PAUSE_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 seed_load_i;
    logic [KEY_BITS-1:0]  seed_key_i;
    logic [IV_BITS-1:0]   seed_iv_i;
    logic                 rand_req_i;
    rand_req_t            rand_req_type_i;
    logic                 stall_i;
    logic                 busy_o;
    logic [BYTE_BITS-1:0] rand_byte_o;
    logic                 rand_valid_o;

    logic [BYTE_BITS-1:0] exp_q [$];     // Bytes owed by accepted requests
    logic [BYTE_BITS-1:0] exp_byte;
    logic [KEY_BITS-1:0]  ref_key;       // Seed of the current stream
    logic [IV_BITS-1:0]   ref_iv;
    logic [KEY_BITS-1:0]  new_key;
    logic [IV_BITS-1:0]   new_iv;
    logic [WORD_BITS-1:0] cached_word;
    int                   cached_idx;    // Index of cached_word in the stream
    int                   byte_pos;      // Next unserved byte of the stream
    int                   seed_dummy;

    rng_top UUT (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .seed_load_i     (seed_load_i),
        .seed_key_i      (seed_key_i),
        .seed_iv_i       (seed_iv_i),
        .rand_req_i      (rand_req_i),
        .rand_req_type_i (rand_req_type_i),
        .busy_o          (busy_o),
        .rand_byte_o     (rand_byte_o),
        .rand_valid_o    (rand_valid_o),
        .stall_i         (stall_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("rand_valid_o", 0, rand_valid_o);
        check_value("busy_o", 0, busy_o);
        check_value("rand_byte_o", 0, rand_byte_o);
    endtask

    // ------------------------------------------------
    // Expected stream
    // ------------------------------------------------
    task automatic queue_bytes(input int count);
        int w;
        repeat (count) begin
            w = byte_pos / BYTES_PER_WORD;
            if (w != cached_idx) begin
                cached_word = trivium_ref_word(ref_key, ref_iv, w);
                cached_idx  = w;
            end
            // LSB byte of each word first
            exp_q.push_back(cached_word[(byte_pos % BYTES_PER_WORD) * BYTE_BITS +: BYTE_BITS]);
            byte_pos++;
        end
    endtask

    task automatic load_seed(input logic [KEY_BITS-1:0] key, input logic [IV_BITS-1:0] iv);
        seed_key_i  = key;
        seed_iv_i   = iv;
        seed_load_i = 1'b1;
        @(negedge clk_i);
        seed_load_i = 1'b0;
        ref_key     = key;       // Stream restarts at word 0
        ref_iv      = iv;
        byte_pos    = 0;
        cached_idx  = -1;
    endtask

    // Called on a negedge with busy_o low
    task automatic send_request(input rand_req_t kind, input bit with_stall);
        queue_bytes((kind == REQ_BURST) ? BURST_BYTES : 1);
        rand_req_i      = 1'b1;
        rand_req_type_i = kind;
        @(negedge clk_i);
        rand_req_i = 1'b0;
        while (busy_o) begin
            if (with_stall) begin
                stall_i = (($urandom % 3) == 0);  // Random alarm pulses
            end
            @(negedge clk_i);
        end
        stall_i = 1'b0;
        check_value("bytes outstanding", 0, exp_q.size());
    endtask

    // mix 0 single bytes, 1 bursts, else random
    task automatic run_requests(input int count, input int mix, input bit with_stall);
        rand_req_t kind;
        repeat (count) begin
            case (mix)
                0:       kind = REQ_BYTE;
                1:       kind = REQ_BURST;
                default: kind = ($urandom % 2) ? REQ_BURST : REQ_BYTE;
            endcase
            send_request(kind, with_stall);
            repeat ($urandom % 4) @(negedge clk_i);
        end
    endtask

    // ------------------------------------------------
    // Byte monitor
    // ------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (stall_i) begin
                check_value("rand_valid_o", 0, rand_valid_o);
            end
            if (rand_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("Byte on rand_byte_o at %0t ns with no byte expected", $time);
                    $display("Checks failed");
                    $fatal(1, "unexpected byte");
                end else begin
                    exp_byte = exp_q.pop_front();
                    check_value("rand_byte_o", exp_byte, rand_byte_o);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial begin
        seed_dummy      = $urandom(50);
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        seed_load_i     = 1'b0;
        seed_key_i      = '0;
        seed_iv_i       = '0;
        rand_req_i      = 1'b0;
        rand_req_type_i = REQ_BYTE;
        stall_i         = 1'b0;
        byte_pos        = 0;
        cached_idx      = -1;

        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            check_idle_outputs();
        end
        rst_n_i = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_idle_outputs();
        end

        load_seed(80'h0f62b5085bae0154a7fa, 80'h288ff65dc42b92f960c7);
        run_requests(12, 0, 1'b0);                // Singles, stream in order
        run_requests(20, 2, 1'b0);                // Mixed singles and bursts
        repeat (PAUSE_CYCLES) @(negedge clk_i);   // Back-pressure up to the core
        run_requests(16, 1, 1'b0);
        run_requests(20, 2, 1'b1);                // Under stall

        new_key = {16'($urandom), $urandom, $urandom};
        new_iv  = {16'($urandom), $urandom, $urandom};
        load_seed(new_key, new_iv);
        run_requests(12, 2, 1'b0);

        repeat (4) @(negedge clk_i);
        if (exp_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d expected bytes never appeared on rand_byte_o", exp_q.size());
            $display("Checks failed");
            $fatal(1, "missing bytes");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+.
rng_pkg.sv
trivium_core.sv
keystream_fifo.sv
byte_server.sv
rng_top.sv
tb_rng_top.sv
